/* rtl/uart_cfg.svh */
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// ticks of the baud divider per serial bit
`define UART_OVERSAMPLE 16

// low ticks in a row before a start bit counts
// half a bit at the default oversampling
`define UART_START_SAMPLES 8

// divisor loaded at reset
// bit time is oversample times (divisor + 1) clocks
`define UART_DEFAULT_DIV 16'd3

// width of the apb address bus
`define APB_ADDR_W 4

`endif

/* rtl/uartPkg.sv */
package uartPkg;

	// receiver walk through one frame
	typedef enum logic [1:0] {
		// waiting for a long enough low on the line
		startSearch = 2'd0,
		// eight data bits at bit centres
		receive = 2'd1,
		// one sample of the stop bit
		stopCheck = 2'd2
	} rxState_e;

	// transmitter walk through one frame
	typedef enum logic [1:0] {
		// line high, ready for a byte
		idle = 2'd0,
		// start bit
		start = 2'd1,
		// eight data bits lsb first
		data = 2'd2,
		// single stop bit
		stop = 2'd3
	} txState_e;

endpackage

/* rtl/apbPkg.sv */
`include "uart_cfg.svh"

package apbPkg;

	// register map
	typedef enum logic [`APB_ADDR_W-1:0] {
		DATA = 4'h0,
		STATUS = 4'h4,
		CFG = 4'h8
	} regAddr_e;

	// write word as seen at the data register
	typedef struct packed {
		logic [23:0] reserved;
		logic [7:0] txByte;
	} txView_s;

	// write word as seen at the configuration register
	typedef struct packed {
		logic [13:0] reserved;
		logic rxEn;
		logic txEn;
		logic [15:0] divisor;
	} cfgView_s;

	// one pwdata word with two meanings by address
	typedef union packed {
		txView_s txView;
		cfgView_s cfgView;
	} regWord_u;

	// status register layout
	typedef struct packed {
		logic [27:0] reserved;
		logic frameErr;
		logic overrun;
		logic txBusy;
		logic rxFull;
	} statusWord_s;

endpackage

/* rtl/baudGen.sv */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module baudGen(
	input logic clk,
	input logic rst,
	input logic [15:0] divisor,
	output logic tick
);

	logic [15:0] count;
	// copy of the divisor to spot a rewrite
	logic [15:0] divisorQ;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			count <= `UART_DEFAULT_DIV;
			divisorQ <= `UART_DEFAULT_DIV;
			tick <= 1'b0;
		end else begin
			divisorQ <= divisor;
			if (divisor != divisorQ) begin
				// new rate starts from a full period
				count <= divisor;
				tick <= 1'b0;
			end else if (count == 16'd0) begin
				count <= divisorQ;
				tick <= 1'b1;
			end else begin
				count <= count - 16'd1;
				tick <= 1'b0;
			end
		end
	end

endmodule

/* rtl/uartRx.sv */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uartRx(
	input logic clk,
	input logic rst,
	input logic tick,
	input logic rxEn,
	input logic rxd,
	output logic valid,
	output logic [7:0] data,
	output logic frameErr
);

	import uartPkg::*;

	localparam int StrtW = $clog2(`UART_START_SAMPLES);
	localparam int StepW = $clog2(`UART_OVERSAMPLE);

	// two flop synchronizer on the pin
	logic [1:0] syncRx;
	logic rxBit;

	rxState_e state;
	// low samples seen so far
	logic [StrtW-1:0] cntStrt;
	// ticks since the last sample
	logic [StepW-1:0] cntStep;
	// data bit position, lsb first
	logic [2:0] place;
	logic [7:0] rxByte;
	logic stepEnd;

	assign rxBit = syncRx[1];
	assign stepEnd = (cntStep == StepW'(`UART_OVERSAMPLE - 1));

	// line idles high so the synchronizer resets high
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			syncRx <= 2'b11;
		end else begin
			syncRx <= {syncRx[0], rxd};
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= startSearch;
			cntStrt <= '0;
			cntStep <= '0;
			place <= 3'd0;
			rxByte <= 8'd0;
			data <= 8'd0;
			valid <= 1'b0;
			frameErr <= 1'b0;
		end else begin
			// single cycle pulses
			valid <= 1'b0;
			frameErr <= 1'b0;
			if (!rxEn) begin
				// disabled receiver parks in search
				state <= startSearch;
				cntStrt <= '0;
			end else if (tick) begin
				case (state)
					startSearch: begin
						if (!rxBit) begin
							if (cntStrt == StrtW'(`UART_START_SAMPLES - 1)) begin
								// now near the start bit centre
								cntStrt <= '0;
								cntStep <= '0;
								place <= 3'd0;
								state <= receive;
							end else begin
								cntStrt <= cntStrt + 1'b1;
							end
						end else begin
							// high sample restarts the count
							cntStrt <= '0;
						end
					end
					receive: begin
						if (stepEnd) begin
							cntStep <= '0;
							rxByte[place] <= rxBit;
							place <= place + 3'd1;
							if (place == 3'd7)
								state <= stopCheck;
						end else begin
							cntStep <= cntStep + 1'b1;
						end
					end
					stopCheck: begin
						if (stepEnd) begin
							cntStep <= '0;
							state <= startSearch;
							if (rxBit) begin
								valid <= 1'b1;
								data <= rxByte;
							end else begin
								// stop bit low means a broken frame
								frameErr <= 1'b1;
							end
						end else begin
							cntStep <= cntStep + 1'b1;
						end
					end
					default: state <= startSearch;
				endcase
			end
		end
	end

endmodule

/* rtl/uartTx.sv */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uartTx(
	input logic clk,
	input logic rst,
	input logic tick,
	input logic txEn,
	input logic txStart,
	input logic [7:0] txData,
	output logic txd,
	output logic txBusy
);

	import uartPkg::*;

	localparam int TickW = $clog2(`UART_OVERSAMPLE);

	txState_e state;
	// ticks inside the current bit
	logic [TickW-1:0] cntTick;
	// data bit being sent
	logic [2:0] place;
	logic [7:0] txByte;
	logic bitStart;
	logic bitEnd;
	logic load;

	// a new level goes out on the first tick of each bit
	assign bitStart = tick && (cntTick == '0);
	assign bitEnd = tick && (cntTick == TickW'(`UART_OVERSAMPLE - 1));
	assign load = (state == idle) && txStart && txEn;

	always_ff @(posedge clk) begin
		if (load)
			txByte <= txData;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= idle;
			cntTick <= '0;
			place <= 3'd0;
			txd <= 1'b1;
			txBusy <= 1'b0;
		end else begin
			// tick count runs only inside a frame
			if (state != idle && tick)
				cntTick <= bitEnd ? '0 : cntTick + 1'b1;
			case (state)
				idle: begin
					if (load) begin
						cntTick <= '0;
						place <= 3'd0;
						txBusy <= 1'b1;
						state <= start;
					end
				end
				start: begin
					if (bitStart)
						txd <= 1'b0;
					if (bitEnd)
						state <= data;
				end
				data: begin
					if (bitStart)
						txd <= txByte[place];
					if (bitEnd) begin
						place <= place + 3'd1;
						if (place == 3'd7)
							state <= stop;
					end
				end
				stop: begin
					if (bitStart)
						txd <= 1'b1;
					// line is already high, so busy can drop here
					if (bitEnd) begin
						txBusy <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

/* rtl/uartRegs.sv */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uartRegs(
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_ADDR_W-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	input logic txBusy,
	input logic rxValid,
	input logic [7:0] rxData,
	input logic rxFrameErr,
	output logic [15:0] divisor,
	output logic txEn,
	output logic rxEn,
	output logic txStart,
	output logic [7:0] txData
);

	import apbPkg::*;

	regAddr_e addr;
	regWord_u wordIn;
	regWord_u cfgWord;
	statusWord_s status;

	logic access;
	logic wrDone;
	logic rdDone;
	logic dataRead;
	logic statusRead;

	// receive holding register and its flags
	logic rxFull;
	logic overrun;
	logic frameErr;
	logic [7:0] rxHold;

	assign addr = regAddr_e'(paddr);
	assign wordIn = pwdata;
	assign access = psel && penable;

	// stall a byte write until the transmitter is free
	assign pready = !(psel && pwrite && addr == DATA && txBusy);

	assign wrDone = access && pready && pwrite;
	assign rdDone = access && pready && !pwrite;
	assign dataRead = rdDone && addr == DATA;
	assign statusRead = rdDone && addr == STATUS;

	always_comb begin
		status = '0;
		status.rxFull = rxFull;
		status.txBusy = txBusy;
		status.overrun = overrun;
		status.frameErr = frameErr;
		cfgWord = '0;
		cfgWord.cfgView.rxEn = rxEn;
		cfgWord.cfgView.txEn = txEn;
		cfgWord.cfgView.divisor = divisor;
		case (addr)
			DATA: prdata = rxFull ? {24'd0, rxHold} : 32'd0;
			STATUS: prdata = status;
			CFG: prdata = cfgWord;
			// holes in the map read zero
			default: prdata = 32'd0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (wrDone && addr == DATA)
			txData <= wordIn.txView.txByte;
		// a full register keeps its byte
		if (rxValid && (!rxFull || dataRead))
			rxHold <= rxData;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			divisor <= `UART_DEFAULT_DIV;
			txEn <= 1'b1;
			rxEn <= 1'b1;
			txStart <= 1'b0;
			rxFull <= 1'b0;
			overrun <= 1'b0;
			frameErr <= 1'b0;
		end else begin
			txStart <= wrDone && addr == DATA;
			if (wrDone && addr == CFG) begin
				divisor <= wordIn.cfgView.divisor;
				txEn <= wordIn.cfgView.txEn;
				rxEn <= wordIn.cfgView.rxEn;
			end
			if (dataRead)
				rxFull <= 1'b0;
			// status read clears sticky flags
			if (statusRead) begin
				overrun <= 1'b0;
				frameErr <= 1'b0;
			end
			// new events win over a clear in the same cycle
			if (rxValid) begin
				if (rxFull && !dataRead)
					overrun <= 1'b1;
				else
					rxFull <= 1'b1;
			end
			if (rxFrameErr)
				frameErr <= 1'b1;
		end
	end

endmodule

/* rtl/uartApb.sv */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uartApb(
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_ADDR_W-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	input logic rxd,
	output logic txd
);

	// configuration from the register block
	logic [15:0] divisor;
	logic txEn;
	logic rxEn;
	// transmit handshake
	logic txStart;
	logic [7:0] txData;
	logic txBusy;
	// oversampling tick shared by both directions
	logic tick;
	// receive results
	logic rxValid;
	logic [7:0] rxData;
	logic rxFrameErr;

	uartRegs uartRegs_inst(
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.txBusy(txBusy),
		.rxValid(rxValid),
		.rxData(rxData),
		.rxFrameErr(rxFrameErr),
		.divisor(divisor),
		.txEn(txEn),
		.rxEn(rxEn),
		.txStart(txStart),
		.txData(txData)
	);

	baudGen baudGen_inst(
		.clk(clk),
		.rst(rst),
		.divisor(divisor),
		.tick(tick)
	);

	uartTx uartTx_inst(
		.clk(clk),
		.rst(rst),
		.tick(tick),
		.txEn(txEn),
		.txStart(txStart),
		.txData(txData),
		.txd(txd),
		.txBusy(txBusy)
	);

	uartRx uartRx_inst(
		.clk(clk),
		.rst(rst),
		.tick(tick),
		.rxEn(rxEn),
		.rxd(rxd),
		.valid(rxValid),
		.data(rxData),
		.frameErr(rxFrameErr)
	);

endmodule

/* verification/uartTb.sv */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uartTb;

	import apbPkg::*;

	// largest divisor the tests program
	localparam int MaxDiv = 7;
	// 37 frames over all tests rounded up
	localparam int Frames = 40;
	localparam int Limit = Frames * 10 * `UART_OVERSAMPLE * (MaxDiv + 1) + 2000;
	// status bits
	localparam logic [31:0] RxFullBit = 32'h1;
	localparam logic [31:0] TxBusyBit = 32'h2;
	localparam logic [31:0] OverrunBit = 32'h4;
	localparam logic [31:0] FrameBit = 32'h8;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_W-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic rxd;
	logic txd;

	// line mux between loopback and bit-banger
	logic loopback;
	logic bangBit;

	// shadow model of the register block
	logic [7:0] lastSent;
	logic [7:0] rxByteS;
	logic rxFullS;
	logic overrunS;
	logic frameErrS;
	logic [15:0] divS;
	logic txEnS;
	logic rxEnS;

	// set while a read has a known answer
	logic checkOn;
	int cycles = 0;

	assign rxd = loopback ? txd : bangBit;

	uartApb uartApb_inst(
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.rxd(rxd),
		.txd(txd)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == Limit) begin
			$display("timeout: tests still running after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$fatal(1, "run stopped at the cycle limit");
		end
	end

	task automatic checkVal(input string name, input logic [31:0] expVal,
			input logic [31:0] actVal);
		if (expVal !== actVal) begin
			$display("ERR %s expected 0x%08h actual 0x%08h", name, expVal, actVal);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// expected prdata from the register map rules
	function automatic logic [31:0] expectRead(input logic [`APB_ADDR_W-1:0] addr,
			input logic [7:0] rxByte, input logic rxFull, input logic txBusy,
			input logic overrun, input logic frameErr, input logic [15:0] div,
			input logic txEn, input logic rxEn);
		statusWord_s st;
		regWord_u cfg;
		logic [31:0] res;
		st = '0;
		st.rxFull = rxFull;
		st.txBusy = txBusy;
		st.overrun = overrun;
		st.frameErr = frameErr;
		cfg = '0;
		cfg.cfgView.rxEn = rxEn;
		cfg.cfgView.txEn = txEn;
		cfg.cfgView.divisor = div;
		case (addr)
			DATA: res = rxFull ? {24'd0, rxByte} : 32'd0;
			STATUS: res = st;
			CFG: res = cfg;
			default: res = 32'd0;
		endcase
		return res;
	endfunction

	// compare every checked read just before it completes
	// transmitter is idle during checked reads
	always @(negedge clk) begin
		if (psel && penable && pready && !pwrite && checkOn)
			checkVal($sformatf("prdata@%h", paddr),
				expectRead(paddr, rxByteS, rxFullS, 1'b0, overrunS, frameErrS,
					divS, txEnS, rxEnS), prdata);
	end

	// apb write that counts access cycles with pready low
	task automatic writeReg(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] wdata,
			output int stalls);
		stalls = 0;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready) begin
			stalls++;
			@(negedge clk);
		end
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic readReg(input logic [`APB_ADDR_W-1:0] addr, input logic checked,
			output logic [31:0] rd);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		checkOn = checked;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		rd = prdata;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		checkOn = 1'b0;
	endtask

	// read status until the cared bits match
	// seen collects every bit read on the way
	task automatic pollStatus(input logic [31:0] care, input logic [31:0] want,
			output logic [31:0] seen);
		logic [31:0] rd;
		seen = '0;
		do begin
			readReg(STATUS, 1'b0, rd);
			seen |= rd;
		end while ((rd & care) != want);
	endtask

	// low time of the next start bit in clocks
	task automatic measureLow(output int cnt);
		cnt = 0;
		@(negedge clk);
		while (txd)
			@(negedge clk);
		while (!txd) begin
			cnt++;
			@(negedge clk);
		end
	endtask

	// one frame on rxd at the programmed bit time
	task automatic sendFrame(input logic [7:0] b, input logic goodStop);
		int period;
		period = `UART_OVERSAMPLE * (int'(divS) + 1);
		@(posedge clk);
		bangBit <= 1'b0;
		repeat (period) @(posedge clk);
		for (int i = 0; i < 8; i++) begin
			bangBit <= b[i];
			repeat (period) @(posedge clk);
		end
		bangBit <= goodStop;
		// a bad stop stays low past its sample only
		// so the receiver sees no new start bit
		repeat (12 * (int'(divS) + 1)) @(posedge clk);
		bangBit <= 1'b1;
		repeat (period) @(posedge clk);
	endtask

	// wait for a byte already written and read it back
	task automatic checkLoop(input logic [7:0] b);
		logic [31:0] seen;
		logic [31:0] rd;
		lastSent = b;
		pollStatus(RxFullBit | TxBusyBit, RxFullBit, seen);
		checkVal("status error flags", 32'd0, seen & (OverrunBit | FrameBit));
		rxByteS = lastSent;
		rxFullS = 1'b1;
		readReg(STATUS, 1'b1, rd);
		readReg(DATA, 1'b1, rd);
		rxFullS = 1'b0;
		readReg(STATUS, 1'b1, rd);
	endtask

	task automatic loopByte(input logic [7:0] b);
		int stalls;
		writeReg(DATA, {24'd0, b}, stalls);
		checkLoop(b);
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] seen;
		regWord_u w;
		logic [7:0] b;
		logic [7:0] b2;
		int s1;
		int s2;
		int lowCnt;
		rst = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		loopback = 1'b1;
		bangBit = 1'b1;
		checkOn = 1'b0;
		lastSent = 8'd0;
		rxByteS = 8'd0;
		rxFullS = 1'b0;
		overrunS = 1'b0;
		frameErrS = 1'b0;
		divS = `UART_DEFAULT_DIV;
		txEnS = 1'b1;
		rxEnS = 1'b1;
		void'($urandom(32'h9b08_82be));
		repeat (8) @(posedge clk);
		rst <= 1'b1;

		// reset values
		readReg(STATUS, 1'b1, rd);
		readReg(CFG, 1'b1, rd);
		@(negedge clk);
		checkVal("txd", 32'd1, {31'd0, txd});

		// loopback at the default rate
		repeat (16) loopByte(8'($urandom));

		// divisor 7 with the first start bit timed on txd
		w = '0;
		w.cfgView.rxEn = 1'b1;
		w.cfgView.txEn = 1'b1;
		w.cfgView.divisor = 16'd7;
		writeReg(CFG, w, s1);
		divS = 16'd7;
		readReg(CFG, 1'b1, rd);
		// lsb set so the start bit ends on a high data bit
		b = 8'($urandom) | 8'h01;
		fork
			writeReg(DATA, {24'd0, b}, s1);
			measureLow(lowCnt);
		join
		checkVal("txd start bit clocks", 32'(`UART_OVERSAMPLE * 8), lowCnt);
		checkLoop(b);
		repeat (15) loopByte(8'($urandom));

		// framing error from the bit-banger
		@(posedge clk);
		loopback <= 1'b0;
		sendFrame(8'($urandom), 1'b0);
		frameErrS = 1'b1;
		readReg(STATUS, 1'b1, rd);
		frameErrS = 1'b0;
		readReg(STATUS, 1'b1, rd);
		@(posedge clk);
		loopback <= 1'b1;

		// overrun keeps the first byte
		b = 8'($urandom);
		b2 = 8'($urandom);
		writeReg(DATA, {24'd0, b}, s1);
		pollStatus(RxFullBit | TxBusyBit, RxFullBit, seen);
		rxByteS = b;
		rxFullS = 1'b1;
		writeReg(DATA, {24'd0, b2}, s1);
		pollStatus(TxBusyBit, 32'd0, seen);
		checkVal("status overrun", OverrunBit, seen & OverrunBit);
		readReg(DATA, 1'b1, rd);
		rxFullS = 1'b0;
		readReg(STATUS, 1'b1, rd);

		// back-pressure on a second byte write
		b = 8'($urandom);
		b2 = 8'($urandom);
		writeReg(DATA, {24'd0, b}, s1);
		writeReg(DATA, {24'd0, b2}, s2);
		checkVal("pready stall first write", 32'd0, s1);
		checkVal("pready stall second write", 32'd1, {31'd0, s2 != 0});
		pollStatus(RxFullBit, RxFullBit, seen);
		rxByteS = b;
		rxFullS = 1'b1;
		readReg(DATA, 1'b1, rd);
		rxFullS = 1'b0;
		checkLoop(b2);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* all.f */
+incdir+rtl
rtl/uartPkg.sv
rtl/apbPkg.sv
rtl/baudGen.sv
rtl/uartRx.sv
rtl/uartTx.sv
rtl/uartRegs.sv
rtl/uartApb.sv
verification/uartTb.sv

/* run.sh */
#!/bin/sh
# build and run the uart testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module uartTb \
	&& ./obj_dir/VuartTb > sim.log 2>&1 \
	|| echo "build or simulation returned an error"

cat sim.log 2>/dev/null

# the log decides, a missing log counts as a failure
! grep -q "RESULT: FAIL" sim.log \
	&& grep -q "RESULT: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
